// File: source/spart_pkg.sv
package spart_pkg;

    // serial bit time in sys_clk cycles
    // short value so simulation runs quickly
    localparam int clks_per_bit = 16;

    // bytes per frame, byte0 goes out first
    localparam int frame_bytes = 3;

    // start bit, 8 data bits, stop bit
    localparam int bits_per_char = 10;

    // counter widths derived from the above
    localparam int clk_cnt_w  = $clog2(clks_per_bit);
    localparam int bit_idx_w  = $clog2(bits_per_char);
    localparam int byte_idx_w = $clog2(frame_bytes);

    // last cycle of a full bit
    localparam logic [clk_cnt_w-1:0] bit_last = clk_cnt_w'(clks_per_bit - 1);
    // last cycle of half a bit, used to reach the start-bit middle
    localparam logic [clk_cnt_w-1:0] half_last = clk_cnt_w'(clks_per_bit / 2 - 1);
    // index of the stop bit inside a character
    localparam logic [bit_idx_w-1:0] stop_idx = bit_idx_w'(bits_per_char - 1);
    // index of the last byte in a frame
    localparam logic [byte_idx_w-1:0] byte_last = byte_idx_w'(frame_bytes - 1);

    // three-byte frame, byte0 in the low bits
    typedef struct packed {
        logic [7:0] byte2;
        logic [7:0] byte1;
        logic [7:0] byte0;
    } frame_t;

    // active-low segments, bit 6 is segment g
    typedef logic [6:0] seg_t;

    // six digits, hex0 shows the lowest nibble
    typedef struct packed {
        seg_t hex5;
        seg_t hex4;
        seg_t hex3;
        seg_t hex2;
        seg_t hex1;
        seg_t hex0;
    } seg_digits_t;

    // every segment dark
    localparam seg_t seg_off = 7'b1111111;

    // font for 0..f, leftmost entry is index 15
    localparam seg_t [15:0] seg_font = {
        7'b0001110,
        7'b0000110,
        7'b0100001,
        7'b1000110,
        7'b0000011,
        7'b0001000,
        7'b0011000,
        7'b0000000,
        7'b1111000,
        7'b0000010,
        7'b0010010,
        7'b0011001,
        7'b0110000,
        7'b0100100,
        7'b1111001,
        7'b1000000
    };

endpackage

// File: source/key_press.sv
`timescale 1ns/1ps

module key_press (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              key_n,
    input  logic [7:0]        sw_byte,
    output logic              send,
    output spart_pkg::frame_t frame
);

    // key synchronizer chain, idle level is high
    logic key_s1;
    logic key_s2;
    logic key_s3;
    // high for the one cycle where the key goes from released to pressed
    logic press;

    // key is active low, so a press is a 1 -> 0 step
    assign press = key_s3 & ~key_s2;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            key_s1 <= 1'b1;
            key_s2 <= 1'b1;
            key_s3 <= 1'b1;
        end else begin
            key_s1 <= key_n;
            key_s2 <= key_s1;
            key_s3 <= key_s2;
        end
    end

    // send strobe lines up with the registered frame
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            send <= 1'b0;
        end else begin
            send <= press;
        end
    end

    // switch byte copied into every frame slot
    // taken on the press cycle, held until the next press
    always_ff @(posedge sys_clk) begin
        if (press) begin
            frame <= '{byte2: sw_byte, byte1: sw_byte, byte0: sw_byte};
        end
    end

endmodule

// File: source/spart_tx.sv
`timescale 1ns/1ps

module spart_tx (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              send,
    input  spart_pkg::frame_t frame,
    output logic              txd,
    output logic              busy
);

    // frame bits still to go, next data bit sits at bit 0
    logic [$bits(spart_pkg::frame_t)-1:0] shift_q;
    // cycles spent in the current bit
    logic [spart_pkg::clk_cnt_w-1:0]      clk_cnt;
    // 0 is start, 1..8 data, 9 stop
    logic [spart_pkg::bit_idx_w-1:0]      bit_idx;
    // byte of the frame being sent
    logic [spart_pkg::byte_idx_w-1:0]     byte_idx;
    // last cycle of the current bit
    logic                                 bit_done;
    // stop bit of a character is on the line
    logic                                 char_done;
    // next bit is the stop bit
    logic                                 to_stop;
    // new frame taken from the producer
    logic                                 load;
    // next bit is a data bit, take it off the shift buffer
    logic                                 next_data;

    assign bit_done  = clk_cnt == spart_pkg::bit_last;
    assign char_done = bit_idx == spart_pkg::stop_idx;
    assign to_stop   = bit_idx == spart_pkg::stop_idx - 1'b1;
    // a strobe during a transfer is dropped
    assign load      = !busy && send;
    assign next_data = busy && bit_done && !char_done && !to_stop;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            txd      <= 1'b1;
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
        end else if (!busy) begin
            clk_cnt  <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            if (send) begin
                // start bit goes out together with busy
                busy <= 1'b1;
                txd  <= 1'b0;
            end
        end else if (bit_done) begin
            clk_cnt <= '0;
            if (char_done) begin
                bit_idx <= '0;
                if (byte_idx == spart_pkg::byte_last) begin
                    // line stays at the stop level
                    busy <= 1'b0;
                end else begin
                    // next byte starts right after the stop bit
                    byte_idx <= byte_idx + 1'b1;
                    txd      <= 1'b0;
                end
            end else begin
                bit_idx <= bit_idx + 1'b1;
                txd     <= to_stop ? 1'b1 : shift_q[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // frame buffer, one bit drops out per data bit
    // after eight shifts the next byte sits at the bottom
    always_ff @(posedge sys_clk) begin
        if (load) begin
            shift_q <= frame;
        end else if (next_data) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: source/spart_rx.sv
`timescale 1ns/1ps

module spart_rx (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              rxd,
    output logic              frame_valid,
    output logic              frame_error,
    output spart_pkg::frame_t frame
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t state;

    // two-stage synchronizer plus one stage for edge detection
    logic rxd_s1;
    logic rxd_s2;
    logic rxd_prev;
    // cycles into the current bit
    logic [spart_pkg::clk_cnt_w-1:0]      clk_cnt;
    // data bits taken in this character
    logic [2:0]                           data_cnt;
    // good bytes collected in this frame
    logic [spart_pkg::byte_idx_w-1:0]     byte_idx;
    // frame assembly, bits enter at the top and move down
    logic [$bits(spart_pkg::frame_t)-1:0] asm_q;
    // middle of a full bit reached
    logic                                 bit_done;

    assign bit_done = clk_cnt == spart_pkg::bit_last;
    // byte0 ends up lowest once all bytes are in
    assign frame    = asm_q;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rxd_s1   <= 1'b1;
            rxd_s2   <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_s1   <= rxd;
            rxd_s2   <= rxd_s1;
            rxd_prev <= rxd_s2;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            clk_cnt     <= '0;
            data_cnt    <= '0;
            byte_idx    <= '0;
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            // flags are single-cycle pulses
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    // falling edge means a start bit
                    if (rxd_prev && !rxd_s2) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (clk_cnt == spart_pkg::half_last) begin
                        clk_cnt  <= '0;
                        data_cnt <= '0;
                        // high at mid start bit is a glitch
                        state    <= rxd_s2 ? st_idle : st_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_done) begin
                        clk_cnt  <= '0;
                        data_cnt <= data_cnt + 1'b1;
                        if (data_cnt == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        state   <= st_idle;
                        if (!rxd_s2) begin
                            // bad stop bit, partial frame thrown away
                            byte_idx    <= '0;
                            frame_error <= 1'b1;
                        end else if (byte_idx == spart_pkg::byte_last) begin
                            byte_idx    <= '0;
                            frame_valid <= 1'b1;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // lsb first, so each new bit lands at the top and shifts down
    always_ff @(posedge sys_clk) begin
        if (state == st_data && bit_done) begin
            asm_q <= {rxd_s2, asm_q[$bits(spart_pkg::frame_t)-1:1]};
        end
    end

endmodule

// File: source/hex_display.sv
`timescale 1ns/1ps

module hex_display (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  logic                   frame_valid,
    input  spart_pkg::frame_t      frame,
    output spart_pkg::seg_digits_t hex
);

    // last good frame from the other board
    spart_pkg::frame_t frame_q;

    // font lookup for one nibble
    // a nibble that matches no entry leaves the digit dark
    function automatic spart_pkg::seg_t nib_to_seg(input logic [3:0] nib);
        spart_pkg::seg_t seg;
        seg = spart_pkg::seg_off;
        for (int i = 0; i < 16; i++) begin
            if (nib == 4'(i)) begin
                seg = spart_pkg::seg_font[i];
            end
        end
        return seg;
    endfunction

    // zero after reset, so all six digits show 0
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            frame_q <= '0;
        end else if (frame_valid) begin
            frame_q <= frame;
        end
    end

    // hex0 is the low nibble of byte0, hex5 the high nibble of byte2
    always_comb begin
        hex.hex0 = nib_to_seg(frame_q.byte0[3:0]);
        hex.hex1 = nib_to_seg(frame_q.byte0[7:4]);
        hex.hex2 = nib_to_seg(frame_q.byte1[3:0]);
        hex.hex3 = nib_to_seg(frame_q.byte1[7:4]);
        hex.hex4 = nib_to_seg(frame_q.byte2[3:0]);
        hex.hex5 = nib_to_seg(frame_q.byte2[7:4]);
    end

endmodule

// File: source/board_top.sv
`timescale 1ns/1ps

module board_top (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  logic [3:0]             key,
    input  logic [9:0]             sw,
    input  logic                   rxd,
    output logic                   txd,
    output logic [9:0]             ledr,
    output spart_pkg::seg_digits_t hex
);

    // outgoing side
    logic              send;
    spart_pkg::frame_t tx_frame;
    logic              busy;
    // incoming side
    logic              frame_valid;
    logic              frame_error;
    spart_pkg::frame_t rx_frame;
    // led state
    logic              err_q;
    logic              frame_tog;

    // key[1] sends the switch byte
    key_press key_press_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .key_n   (key[1]),
        .sw_byte (sw[7:0]),
        .send    (send),
        .frame   (tx_frame)
    );

    spart_tx spart_tx_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .send    (send),
        .frame   (tx_frame),
        .txd     (txd),
        .busy    (busy)
    );

    spart_rx spart_rx_i (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .rxd         (rxd),
        .frame_valid (frame_valid),
        .frame_error (frame_error),
        .frame       (rx_frame)
    );

    hex_display hex_display_i (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame       (rx_frame),
        .hex         (hex)
    );

    // error flag holds until reset, toggle marks each received frame
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            err_q     <= 1'b0;
            frame_tog <= 1'b0;
        end else begin
            if (frame_error) begin
                err_q <= 1'b1;
            end
            if (frame_valid) begin
                frame_tog <= ~frame_tog;
            end
        end
    end

    assign ledr = {7'b0, frame_tog, err_q, busy};

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic sys_clk,
    output logic rst_n
);

    // 8 ns period
    localparam realtime half_period = 4.0;

    initial sys_clk = 1'b0;
    always #(half_period) sys_clk = ~sys_clk;

    // reset held low over the first four rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge sys_clk);
        rst_n <= 1'b1;
    end

endmodule

// File: testbench/board_top_tb.sv
`timescale 1ns/1ps

module board_top_tb;

    // bits per serial character with start and stop
    localparam int char_bits = 10;
    localparam int bit_len   = spart_pkg::clks_per_bit;
    localparam int frame_len = char_bits * spart_pkg::frame_bytes * bit_len;
    // frames summed over all tests with the bad and good driven ones counted as two
    localparam int n_frames  = 13;
    localparam int timeout_cycles = n_frames * frame_len * 3 / 2 + 2000;

    logic                   sys_clk;
    logic                   rst_n;
    logic [3:0]             key;
    logic [9:0]             sw;
    logic                   rxd;
    logic                   txd;
    logic [9:0]             ledr;
    spart_pkg::seg_digits_t hex;

    // rxd source select where 1 loops txd back
    logic                   loop_sel;
    logic                   drv_rxd;

    // comparator request and expected values
    logic                   cmp_req;
    spart_pkg::seg_digits_t exp_hex;
    logic [9:0]             exp_led;

    // model state kept by the stimulus
    logic                   exp_tog;
    logic                   exp_err;
    logic [23:0]            last_frame;
    logic [31:0]            lfsr_state;

    int err_count;
    int test_err_base;
    int tests_passed;
    int tests_failed;
    int cycle_cnt;

    assign rxd = loop_sel ? txd : drv_rxd;

    tb_clock tb_clock_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n)
    );

    board_top dut_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .key     (key),
        .sw      (sw),
        .rxd     (rxd),
        .txd     (txd),
        .ledr    (ledr),
        .hex     (hex)
    );

    // active-low font with segment g in the top bit
    function automatic spart_pkg::seg_t font_ref(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0011000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // expected digits with hex0 from bits 3:0 up to hex5 from bits 23:20
    function automatic spart_pkg::seg_digits_t ref_digits(input logic [23:0] f);
        spart_pkg::seg_digits_t d;
        d.hex0 = font_ref(f[3:0]);
        d.hex1 = font_ref(f[7:4]);
        d.hex2 = font_ref(f[11:8]);
        d.hex3 = font_ref(f[15:12]);
        d.hex4 = font_ref(f[19:16]);
        d.hex5 = font_ref(f[23:20]);
        return d;
    endfunction

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit drawn
    task automatic draw_bits(input int n, output logic [7:0] val);
        int b;
        val = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    // compare hex and leds on the edge after the request
    always @(posedge sys_clk) begin
        if (cmp_req) begin
            if (hex !== exp_hex) begin
                $display("[ERROR] hex: got %h expected %h", hex, exp_hex);
                err_count++;
            end
            if (ledr !== exp_led) begin
                $display("[ERROR] ledr: got %h expected %h", ledr, exp_led);
                err_count++;
            end
        end
    end

    // watchdog
    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic request_check(input logic [23:0] frame_val);
        @(posedge sys_clk);
        exp_hex <= ref_digits(frame_val);
        // busy is expected low whenever a check runs
        exp_led <= {7'b0, exp_tog, exp_err, 1'b0};
        cmp_req <= 1'b1;
        @(posedge sys_clk);
        cmp_req <= 1'b0;
        @(posedge sys_clk);
    endtask

    // key[1] low long enough to pass the synchronizer
    task automatic press_key(input logic [7:0] val);
        @(posedge sys_clk);
        sw     <= {2'b00, val};
        key[1] <= 1'b0;
        repeat (4) @(posedge sys_clk);
        key[1] <= 1'b1;
    endtask

    // busy up and down and then two bits for the receive side
    task automatic wait_tx_done();
        while (!ledr[0]) @(posedge sys_clk);
        while (ledr[0]) @(posedge sys_clk);
        repeat (2 * bit_len) @(posedge sys_clk);
    endtask

    // txd sampled mid-bit from the first start bit
    task automatic check_serial(input logic [7:0] val);
        int k;
        logic exp_bit;
        while (txd) @(posedge sys_clk);
        repeat (bit_len / 2 - 1) @(posedge sys_clk);
        for (k = 0; k < char_bits * spart_pkg::frame_bytes; k++) begin
            case (k % char_bits)
                0: exp_bit = 1'b0;
                char_bits - 1: exp_bit = 1'b1;
                default: exp_bit = val[k % char_bits - 1];
            endcase
            if (txd !== exp_bit) begin
                $display("[ERROR] txd bit %0d: got %h expected %h", k, txd, exp_bit);
                err_count++;
            end
            if (k != char_bits * spart_pkg::frame_bytes - 1) begin
                repeat (bit_len) @(posedge sys_clk);
            end
        end
    endtask

    task automatic drive_bit(input logic level);
        drv_rxd <= level;
        repeat (bit_len) @(posedge sys_clk);
    endtask

    // lsb first with the stop level chosen by the caller
    task automatic drive_byte(input logic [7:0] val, input logic stop_level);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(val[i]);
        end
        drive_bit(stop_level);
    endtask

    task automatic begin_test();
        test_err_base = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_err_base) begin
            $display("test %s: pass", name);
            tests_passed++;
        end else begin
            $display("test %s: fail, %0d errors", name, err_count - test_err_base);
            tests_failed++;
        end
    endtask

    initial begin
        logic [7:0] val;
        logic [7:0] val_b;
        logic [7:0] r;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [3:0] nib [16];
        logic [3:0] tmp;
        int i;
        int j;
        key      <= 4'hf;
        sw       <= '0;
        drv_rxd  <= 1'b1;
        loop_sel <= 1'b1;
        cmp_req  <= 1'b0;
        exp_hex  <= '0;
        exp_led  <= '0;
        cycle_cnt     = 0;
        err_count     = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        lfsr_state    = 32'hd237;
        exp_tog       = 1'b0;
        exp_err       = 1'b0;
        last_frame    = '0;
        @(posedge sys_clk);
        while (rst_n !== 1'b1) @(posedge sys_clk);

        // idle state after reset
        begin_test();
        request_check(24'h0);
        if (txd !== 1'b1) begin
            $display("[ERROR] txd: got %h expected %h", txd, 1'b1);
            err_count++;
        end
        end_test("reset");

        // one press looped back
        begin_test();
        val = 8'h3c;
        press_key(val);
        wait_tx_done();
        exp_tog = ~exp_tog;
        last_frame = {val, val, val};
        request_check(last_frame);
        end_test("single press");

        // line format of a whole frame
        begin_test();
        val = 8'hb4;
        press_key(val);
        check_serial(val);
        wait_tx_done();
        exp_tog = ~exp_tog;
        last_frame = {val, val, val};
        request_check(last_frame);
        end_test("serial format");

        // shuffled nibbles paired into eight bytes
        begin_test();
        for (i = 0; i < 16; i++) begin
            nib[i] = 4'(i);
        end
        for (i = 15; i > 0; i--) begin
            draw_bits(4, r);
            j = int'(r) % (i + 1);
            tmp = nib[i];
            nib[i] = nib[j];
            nib[j] = tmp;
        end
        for (i = 0; i < 8; i++) begin
            val = {nib[2 * i + 1], nib[2 * i]};
            press_key(val);
            wait_tx_done();
            exp_tog = ~exp_tog;
            last_frame = {val, val, val};
            request_check(last_frame);
        end
        end_test("random traffic");

        // second press lands mid-frame
        begin_test();
        draw_bits(8, val);
        val_b = ~val;
        press_key(val);
        while (!ledr[0]) @(posedge sys_clk);
        repeat (3 * bit_len) @(posedge sys_clk);
        press_key(val_b);
        wait_tx_done();
        exp_tog = ~exp_tog;
        last_frame = {val, val, val};
        request_check(last_frame);
        end_test("press while busy");

        // driven input with a bad stop on byte1 and the rest of that frame never sent
        begin_test();
        @(posedge sys_clk);
        loop_sel <= 1'b0;
        @(posedge sys_clk);
        draw_bits(8, b0);
        draw_bits(8, b1);
        drive_byte(b0, 1'b1);
        drive_byte(b1, 1'b0);
        drive_bit(1'b1);
        drive_bit(1'b1);
        // error led marks the end of the bad frame
        while (!ledr[1]) @(posedge sys_clk);
        exp_err = 1'b1;
        request_check(last_frame);
        draw_bits(8, b0);
        draw_bits(8, b1);
        draw_bits(8, b2);
        drive_byte(b0, 1'b1);
        drive_byte(b1, 1'b1);
        drive_byte(b2, 1'b1);
        // frame led toggles once the good frame is in
        while (ledr[2] === exp_tog) @(posedge sys_clk);
        exp_tog = ~exp_tog;
        last_frame = {b2, b1, b0};
        request_check(last_frame);
        end_test("framing error");

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sim.f
source/spart_pkg.sv
source/key_press.sv
source/spart_tx.sv
source/spart_rx.sv
source/hex_display.sv
source/board_top.sv
testbench/tb_clock.sv
testbench/board_top_tb.sv
